// ==== src.f ====
rv_pkg.sv
rv_fwd_if.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_mem_wb.sv
rv_core.sv
tb_rv_core.sv

// ==== Makefile ====
TB       = tb_rv_core
FAIL_MSG = FAIL: see errors above

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module rv_core -f src.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TB) -f src.f
	./obj_dir/V$(TB) > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@if grep -q "$(FAIL_MSG)" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== tb_rv_core.sv ====
`timescale 1ns/10ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int n_body    = 200;
    localparam int prog_len  = n_body + 8;
    localparam int mem_words = 256;
    localparam int limit     = prog_len * 8 + 100;
    localparam int final_idx = 128;

    logic   clk;
    logic   rst;
    instr_t instruction = nop_instr;
    word_t  d_read_data = '0;
    addr_t  pc;
    logic   imem_read, mem_read, mem_write;
    addr_t  d_address;
    word_t  d_write_data, write_back_data;

    instr_t      imem [mem_words];
    word_t       dmem [mem_words];
    word_t       model_mem [mem_words];
    word_t       model_regs [32];
    addr_t       exp_addr [$];
    word_t       exp_data [$];
    word_t       exp_load [$];
    logic [31:0] lfsr_state;
    int          errors;
    int          store_errors = 0;
    int          n_stores = 0;
    int          load_errors = 0;
    int          n_loads = 0;
    logic        load_in_wb = 1'b0;

    rv_core u_rv_core (
        .clk(clk), .rst(rst), .instruction(instruction), .d_read_data(d_read_data),
        .pc(pc), .imem_read(imem_read), .mem_read(mem_read), .mem_write(mem_write),
        .d_address(d_address), .d_write_data(d_write_data),
        .write_back_data(write_back_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // Random source
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int bits;
        bits = 0;
        for (int k = 0; k < n; k++) begin
            bits = (bits << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    // Power-up data memory contents, different in every word
    function automatic word_t fill_word(input int i);
        return (32'(i) * 32'h9E37_79B1) ^ 32'h5A5A_0000;
    endfunction

    function automatic instr_t enc_store(input reg_idx_t src, input logic [11:0] off);
        return {off[11:5], src, 5'd0, 3'b010, off[4:0], op_store};
    endfunction

    function automatic instr_t enc_branch(input logic [2:0] f3, input reg_idx_t a,
                                          input reg_idx_t b, input logic [12:0] off);
        return {off[12], off[10:5], b, a, f3, off[4:1], off[11], op_branch};
    endfunction

    ////////////////////////////////////////
    // Program generator
    task automatic build_program();
        int       kind;
        int       f3;
        int       k;
        logic     alt;
        logic     prev_load;
        reg_idx_t rd, rs1, rs2, prev_rd;
        prev_load = 1'b0;
        prev_rd   = '0;
        imem      = '{default: nop_instr};
        for (int i = 0; i < n_body; i++) begin
            kind = take_bits(3);
            rd   = reg_idx_t'(take_bits(3));
            rs1  = reg_idx_t'(take_bits(3));
            rs2  = reg_idx_t'(take_bits(3));
            // Lean towards reading the register a load just wrote
            if (prev_load && take_bits(1) == 1) begin
                rs1 = prev_rd;
            end
            if (prev_load && take_bits(1) == 1) begin
                rs2 = prev_rd;
            end
            case (kind)
                0, 1: begin
                    f3  = take_bits(3);
                    alt = (f3 == 0 || f3 == 5) ? 1'(take_bits(1)) : 1'b0;
                    imem[8'(i)] = {1'b0, alt, 5'd0, rs2, rs1, 3'(f3), rd, op_reg};
                end
                2, 3: begin
                    f3 = take_bits(3);
                    if (f3 == 1 || f3 == 5) begin
                        alt = (f3 == 5) ? 1'(take_bits(1)) : 1'b0;
                        imem[8'(i)] = {1'b0, alt, 5'd0, 5'(take_bits(5)), rs1, 3'(f3), rd,
                                       op_imm};
                    end else begin
                        imem[8'(i)] = {12'(take_bits(12)), rs1, 3'(f3), rd, op_imm};
                    end
                end
                4: imem[8'(i)] = {12'(take_bits(6) * 4), 5'd0, 3'b010, rd, op_load};
                5: imem[8'(i)] = enc_store(rs2, 12'(take_bits(6) * 4));
                default: begin
                    f3 = take_bits(3) % 6;
                    f3 = (f3 < 2) ? f3 : f3 + 2;
                    k  = 1 + take_bits(2);
                    // Never jump past the closing stores
                    if (i + k > n_body) begin
                        k = n_body - i;
                    end
                    imem[8'(i)] = enc_branch(3'(f3), rs1, rs2, 13'(k * 4));
                end
            endcase
            prev_load = (kind == 4);
            prev_rd   = rd;
        end
        for (int r = 1; r < 8; r++) begin
            imem[8'(n_body + r - 1)] = enc_store(reg_idx_t'(r), 12'((final_idx + r - 1) * 4));
        end
        imem[8'(n_body + 7)] = enc_branch(3'b000, 5'd0, 5'd0, 13'd0);
    endtask

    ////////////////////////////////////////
    // ISA model
    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'd0, $signed(a) < $signed(b)};
            3'b011: return {31'd0, a < b};
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return sa >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic run_model();
        instr_t      w;
        int          idx;
        word_t       a, b, imm_i, addr;
        logic [12:0] boff;
        logic        taken;
        idx        = 0;
        model_regs = '{default: '0};
        for (int i = 0; i < mem_words; i++) begin
            model_mem[8'(i)] = fill_word(i);
        end
        // Branches only go forward, so the halt word is always reached
        while (idx < n_body + 7) begin
            w     = imem[8'(idx)];
            a     = model_regs[w[19:15]];
            b     = model_regs[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            boff  = {w[31], w[7], w[30:25], w[11:8], 1'b0};
            idx   = idx + 1;
            case (w[6:0])
                op_reg: model_regs[w[11:7]] = alu_model(w[14:12], w[30], a, b);
                op_imm: model_regs[w[11:7]] =
                    alu_model(w[14:12], w[30] && (w[14:12] == 3'b101), a, imm_i);
                op_load: begin
                    addr = a + imm_i;
                    model_regs[w[11:7]] = model_mem[addr[9:2]];
                    exp_load.push_back(model_mem[addr[9:2]]);
                end
                op_store: begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    model_mem[addr[9:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                op_branch: begin
                    case (w[14:12])
                        3'b000:  taken = (a == b);
                        3'b001:  taken = (a != b);
                        3'b100:  taken = ($signed(a) < $signed(b));
                        3'b101:  taken = ($signed(a) >= $signed(b));
                        3'b110:  taken = (a < b);
                        default: taken = (a >= b);
                    endcase
                    if (taken) begin
                        idx = idx - 1 + int'(boff[9:2]);
                    end
                end
                default: ;
            endcase
            model_regs[0] = '0;
        end
    endtask

    ////////////////////////////////////////
    // Instruction and data memories
    always @(posedge clk) begin
        if (imem_read) begin
            instruction <= imem[pc[9:2]];
        end
        if (rst) begin
            for (int i = 0; i < mem_words; i++) begin
                dmem[8'(i)] <= fill_word(i);
            end
        end else if (mem_write) begin
            dmem[d_address[9:2]] <= d_write_data;
        end
        if (mem_read) begin
            d_read_data <= dmem[d_address[9:2]];
        end
    end

    // Store monitor, in program order against the model
    always @(negedge clk) begin
        if (!rst && mem_write) begin
            assert (n_stores < exp_addr.size())
            else begin
                store_errors++;
                $display("Unexpected store to address %h after all expected stores", d_address);
            end
            if (n_stores < exp_addr.size()) begin
                assert (d_address == exp_addr[n_stores])
                else begin
                    store_errors++;
                    $display("[ERROR] d_address: got %h, expected %h (store %0d)",
                             d_address, exp_addr[n_stores], n_stores);
                end
                assert (d_write_data == exp_data[n_stores])
                else begin
                    store_errors++;
                    $display("[ERROR] d_write_data: got %h, expected %h (store %0d)",
                             d_write_data, exp_data[n_stores], n_stores);
                end
            end
            n_stores++;
        end
    end

    // Load monitor, the loaded word is on write_back_data one cycle after the read
    always @(negedge clk) begin
        if (!rst && load_in_wb) begin
            assert (n_loads < exp_load.size())
            else begin
                load_errors++;
                $display("Unexpected load result %h after all expected loads",
                         write_back_data);
            end
            if (n_loads < exp_load.size()) begin
                assert (write_back_data == exp_load[n_loads])
                else begin
                    load_errors++;
                    $display("[ERROR] write_back_data: got %h, expected %h (load %0d)",
                             write_back_data, exp_load[n_loads], n_loads);
                end
            end
            n_loads++;
        end
        load_in_wb = !rst && mem_read;
    end

    initial begin
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles with %0d of %0d stores seen",
                 limit, n_stores, exp_addr.size());
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        errors     = 0;
        lfsr_state = 32'd10;
        build_program();
        run_model();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (pc == reset_pc)
        else begin
            errors++;
            $display("[ERROR] pc: got %h, expected %h", pc, reset_pc);
        end
        assert (mem_write == 1'b0)
        else begin
            errors++;
            $display("[ERROR] mem_write: got %h, expected 0", mem_write);
        end
        wait (n_stores == exp_addr.size());
        // Room for any stray write from the wrong path behind the halt loop
        repeat (40) @(posedge clk);
        @(negedge clk);
        assert (n_stores == exp_addr.size())
        else begin
            errors++;
            $display("Store count %0d differs from the model count %0d",
                     n_stores, exp_addr.size());
        end
        assert (n_loads == exp_load.size())
        else begin
            errors++;
            $display("Load count %0d differs from the model count %0d",
                     n_loads, exp_load.size());
        end
        for (int r = 1; r < 8; r++) begin
            assert (dmem[8'(final_idx + r - 1)] == model_regs[5'(r)])
            else begin
                errors++;
                $display("[ERROR] dmem[%h] (x%0d): got %h, expected %h", final_idx + r - 1,
                         r, dmem[8'(final_idx + r - 1)], model_regs[5'(r)]);
            end
        end
        $display("Errors: %0d general, %0d in stores, %0d in loads, %0d of %0d stores seen",
                 errors, store_errors, load_errors, n_stores, exp_addr.size());
        if (errors == 0 && store_errors == 0 && load_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/10ps

module rv_core (
    input  logic           clk,
    input  logic           rst,
    input  rv_pkg::instr_t instruction,
    input  rv_pkg::word_t  d_read_data,
    output rv_pkg::addr_t  pc,
    output logic           imem_read,
    output logic           mem_read,
    output logic           mem_write,
    output rv_pkg::addr_t  d_address,
    output rv_pkg::word_t  d_write_data,
    output rv_pkg::word_t  write_back_data
);
    import rv_pkg::*;

    addr_t    id_pc, branch_target, ex_target;
    logic     stall, redirect, flush_late, flush;
    alu_op_t  alu_op;
    logic     use_imm, is_load, is_store, is_branch, reg_write;
    word_t    imm, rs1_data, rs2_data;
    reg_idx_t rs1, rs2;
    instr_t   ex_instr;
    word_t    ex_result, ex_store_data;
    logic     ex_taken, ex_load, ex_store, ex_reg_write;

    rv_fwd_if u_fwd ();

    // Wrong-path words are dropped for two cycles after a taken branch
    assign flush = redirect | flush_late;
    assign rs1   = instruction[19:15];
    assign rs2   = instruction[24:20];

    rv_fetch u_fetch (
        .clk(clk), .rst(rst), .stall(stall), .redirect(redirect),
        .branch_target(branch_target), .pc(pc), .id_pc(id_pc), .imem_read(imem_read)
    );

    rv_decode u_decode (
        .instr(instruction), .alu_op(alu_op), .use_imm(use_imm), .is_load(is_load),
        .is_store(is_store), .is_branch(is_branch), .reg_write(reg_write), .imm(imm)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .fwd(u_fwd.sink),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    rv_execute u_execute (
        .clk(clk), .rst(rst), .id_instr(instruction), .id_pc(id_pc), .alu_op_in(alu_op),
        .use_imm(use_imm), .is_load(is_load), .is_store(is_store), .is_branch(is_branch),
        .reg_write(reg_write), .imm(imm), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .flush(flush), .fwd(u_fwd.sink), .stall(stall), .ex_instr(ex_instr),
        .ex_result(ex_result), .ex_store_data(ex_store_data), .ex_target(ex_target),
        .ex_taken(ex_taken), .ex_load(ex_load), .ex_store(ex_store),
        .ex_reg_write(ex_reg_write)
    );

    rv_mem_wb u_mem_wb (
        .clk(clk), .rst(rst), .ex_instr(ex_instr), .ex_result(ex_result),
        .ex_store_data(ex_store_data), .ex_target(ex_target), .ex_taken(ex_taken),
        .ex_load(ex_load), .ex_store(ex_store), .ex_reg_write(ex_reg_write),
        .d_read_data(d_read_data), .fwd(u_fwd.source), .redirect(redirect),
        .flush_late(flush_late), .branch_target(branch_target), .mem_read(mem_read),
        .mem_write(mem_write), .d_address(d_address), .d_write_data(d_write_data),
        .write_back_data(write_back_data)
    );

endmodule

// ==== rv_mem_wb.sv ====
`timescale 1ns/10ps

module rv_mem_wb (
    input  logic           clk,
    input  logic           rst,
    input  rv_pkg::instr_t ex_instr,
    input  rv_pkg::word_t  ex_result,
    input  rv_pkg::word_t  ex_store_data,
    input  rv_pkg::addr_t  ex_target,
    input  logic           ex_taken,
    input  logic           ex_load,
    input  logic           ex_store,
    input  logic           ex_reg_write,
    input  rv_pkg::word_t  d_read_data,
    rv_fwd_if.source       fwd,
    output logic           redirect,
    output logic           flush_late,
    output rv_pkg::addr_t  branch_target,
    output logic           mem_read,
    output logic           mem_write,
    output rv_pkg::word_t  d_address,
    output rv_pkg::word_t  d_write_data,
    output rv_pkg::word_t  write_back_data
);
    import rv_pkg::*;

    instr_t   mem_instr;
    word_t    mem_result, mem_store_data;
    addr_t    mem_target;
    logic     mem_taken, mem_load, mem_store, mem_reg_write;
    word_t    wb_result;
    reg_idx_t wb_rd;
    logic     wb_load, wb_reg_write;

    ////////////////////////////////////////
    // EX/MEM register, squashed behind a taken branch
    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            mem_instr     <= nop_instr;
            mem_taken     <= 1'b0;
            mem_load      <= 1'b0;
            mem_store     <= 1'b0;
            mem_reg_write <= 1'b0;
        end else begin
            mem_instr     <= ex_instr;
            mem_taken     <= ex_taken;
            mem_load      <= ex_load;
            mem_store     <= ex_store;
            mem_reg_write <= ex_reg_write;
        end
        mem_result     <= ex_result;
        mem_store_data <= ex_store_data;
        mem_target     <= ex_target;
    end

    assign redirect      = mem_taken;
    assign branch_target = mem_target;
    assign mem_read      = mem_load;
    assign mem_write     = mem_store;
    assign d_address     = mem_result;
    assign d_write_data  = mem_store_data;

    // One more bubble for the word fetched in the redirect cycle
    // The word read during reset is fetched again from reset_pc and is dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_late <= 1'b1;
        end else begin
            flush_late <= redirect;
        end
    end

    ////////////////////////////////////////
    // MEM/WB register
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_rd        <= '0;
            wb_load      <= 1'b0;
            wb_reg_write <= 1'b0;
        end else begin
            wb_rd        <= mem_instr[11:7];
            wb_load      <= mem_load;
            wb_reg_write <= mem_reg_write;
        end
        wb_result <= mem_result;
    end

    // Load data arrives from memory in this cycle
    assign write_back_data = wb_load ? d_read_data : wb_result;

    assign fwd.mem_reg_write = mem_reg_write;
    assign fwd.mem_rd        = mem_instr[11:7];
    assign fwd.mem_result    = mem_result;
    assign fwd.wb_reg_write  = wb_reg_write;
    assign fwd.wb_rd         = wb_rd;
    assign fwd.wb_data       = write_back_data;

endmodule

// ==== rv_execute.sv ====
`timescale 1ns/10ps

module rv_execute (
    input  logic            clk,
    input  logic            rst,
    input  rv_pkg::instr_t  id_instr,
    input  rv_pkg::addr_t   id_pc,
    input  rv_pkg::alu_op_t alu_op_in,
    input  logic            use_imm,
    input  logic            is_load,
    input  logic            is_store,
    input  logic            is_branch,
    input  logic            reg_write,
    input  rv_pkg::word_t   imm,
    input  rv_pkg::word_t   rs1_data,
    input  rv_pkg::word_t   rs2_data,
    input  logic            flush,
    rv_fwd_if.sink          fwd,
    output logic            stall,
    output rv_pkg::instr_t  ex_instr,
    output rv_pkg::word_t   ex_result,
    output rv_pkg::word_t   ex_store_data,
    output rv_pkg::addr_t   ex_target,
    output logic            ex_taken,
    output logic            ex_load,
    output logic            ex_store,
    output logic            ex_reg_write
);
    import rv_pkg::*;

    alu_op_t  ex_alu_op;
    logic     ex_use_imm, ex_branch;
    addr_t    ex_pc;
    word_t    ex_imm;
    reg_idx_t ex_rs1, ex_rs2, ex_rd;
    word_t    op_a, op_b, alu_b;
    logic     eq, lt, ltu, cond;

    ////////////////////////////////////////
    // ID/EX register
    always_ff @(posedge clk) begin
        if (rst || flush || stall) begin
            ex_instr     <= nop_instr;
            ex_alu_op    <= alu_add;
            ex_use_imm   <= 1'b0;
            ex_load      <= 1'b0;
            ex_store     <= 1'b0;
            ex_branch    <= 1'b0;
            ex_reg_write <= 1'b0;
        end else begin
            ex_instr     <= id_instr;
            ex_alu_op    <= alu_op_in;
            ex_use_imm   <= use_imm;
            ex_load      <= is_load;
            ex_store     <= is_store;
            ex_branch    <= is_branch;
            ex_reg_write <= reg_write;
        end
        ex_pc  <= id_pc;
        ex_imm <= imm;
    end

    assign ex_rs1 = ex_instr[19:15];
    assign ex_rs2 = ex_instr[24:20];
    assign ex_rd  = ex_instr[11:7];

    // Load result is not ready until writeback, hold decode one cycle
    assign stall = ex_load && !flush
                   && (ex_rd == id_instr[19:15] || ex_rd == id_instr[24:20]);

    ////////////////////////////////////////
    // Operand forwarding, memory stage wins
    always_comb begin
        if (fwd.mem_reg_write && fwd.mem_rd != '0 && fwd.mem_rd == ex_rs1) begin
            op_a = fwd.mem_result;
        end else if (fwd.wb_reg_write && fwd.wb_rd != '0 && fwd.wb_rd == ex_rs1) begin
            op_a = fwd.wb_data;
        end else begin
            op_a = rs1_data;
        end
        if (fwd.mem_reg_write && fwd.mem_rd != '0 && fwd.mem_rd == ex_rs2) begin
            op_b = fwd.mem_result;
        end else if (fwd.wb_reg_write && fwd.wb_rd != '0 && fwd.wb_rd == ex_rs2) begin
            op_b = fwd.wb_data;
        end else begin
            op_b = rs2_data;
        end
    end

    assign alu_b         = ex_use_imm ? ex_imm : op_b;
    assign ex_store_data = op_b;

    always_comb begin
        case (ex_alu_op)
            alu_add:  ex_result = op_a + alu_b;
            alu_sub:  ex_result = op_a - alu_b;
            alu_slt:  ex_result = word_t'($signed(op_a) < $signed(alu_b));
            alu_sltu: ex_result = word_t'(op_a < alu_b);
            alu_xor:  ex_result = op_a ^ alu_b;
            alu_or:   ex_result = op_a | alu_b;
            alu_and:  ex_result = op_a & alu_b;
            alu_sll:  ex_result = op_a << alu_b[4:0];
            alu_srl:  ex_result = op_a >> alu_b[4:0];
            alu_sra:  ex_result = $signed(op_a) >>> alu_b[4:0];
            default:  ex_result = '0;
        endcase
    end

    // Branch compare on the forwarded register operands
    assign eq  = (op_a == op_b);
    assign lt  = ($signed(op_a) < $signed(op_b));
    assign ltu = (op_a < op_b);

    always_comb begin
        case (ex_instr[14:12])
            f3_beq:  cond = eq;
            f3_bne:  cond = !eq;
            f3_blt:  cond = lt;
            f3_bge:  cond = !lt;
            f3_bltu: cond = ltu;
            f3_bgeu: cond = !ltu;
            default: cond = 1'b0;
        endcase
    end

    assign ex_taken  = ex_branch && cond;
    assign ex_target = ex_pc + ex_imm;

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/10ps

module rv_regfile (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    rv_fwd_if.sink           fwd,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data
);
    import rv_pkg::*;

    word_t regs [32];
    logic  wr_en;

    // x0 is never written, so it reads as zero
    assign wr_en = fwd.wb_reg_write && (fwd.wb_rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
            rs1_data <= '0;
            rs2_data <= '0;
        end else begin
            if (wr_en) begin
                regs[fwd.wb_rd] <= fwd.wb_data;
            end
            // Write-through for a read of the register being written
            rs1_data <= (wr_en && rs1 == fwd.wb_rd) ? fwd.wb_data : regs[rs1];
            rs2_data <= (wr_en && rs2 == fwd.wb_rd) ? fwd.wb_data : regs[rs2];
        end
    end

endmodule

// ==== rv_decode.sv ====
`timescale 1ns/10ps

module rv_decode (
    input  rv_pkg::instr_t  instr,
    output rv_pkg::alu_op_t alu_op,
    output logic            use_imm,
    output logic            is_load,
    output logic            is_store,
    output logic            is_branch,
    output logic            reg_write,
    output rv_pkg::word_t   imm
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign alt    = instr[funct7_alt];

    always_comb begin
        alu_op    = alu_add;
        use_imm   = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        reg_write = 1'b0;
        case (opcode)
            op_reg, op_imm: begin
                case (funct3)
                    f3_add:  alu_op = (opcode == op_reg && alt) ? alu_sub : alu_add;
                    f3_sll:  alu_op = alu_sll;
                    f3_slt:  alu_op = alu_slt;
                    f3_sltu: alu_op = alu_sltu;
                    f3_xor:  alu_op = alu_xor;
                    f3_srl:  alu_op = alt ? alu_sra : alu_srl;
                    f3_or:   alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
                use_imm   = (opcode == op_imm);
                reg_write = 1'b1;
            end
            op_load: begin
                use_imm   = 1'b1;
                is_load   = 1'b1;
                reg_write = 1'b1;
            end
            op_store: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            op_branch: is_branch = 1'b1;
            default: ;  // Anything else passes through as a bubble
        endcase
    end

    ////////////////////////////////////////
    // Immediate generation
    always_comb begin
        case (opcode)
            op_store:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            op_branch: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};
            default: begin
                if (opcode == op_imm && (funct3 == f3_sll || funct3 == f3_srl)) begin
                    imm = {27'd0, instr[24:20]};
                end else begin
                    imm = {{20{instr[31]}}, instr[31:20]};
                end
            end
        endcase
    end

endmodule

// ==== rv_fetch.sv ====
`timescale 1ns/10ps

module rv_fetch (
    input  logic          clk,
    input  logic          rst,
    input  logic          stall,
    input  logic          redirect,
    input  rv_pkg::addr_t branch_target,
    output rv_pkg::addr_t pc,
    output rv_pkg::addr_t id_pc,
    output logic          imem_read
);
    import rv_pkg::*;

    // Memory holds its output word while the read is off
    assign imem_read = ~stall;

    // id_pc follows pc one cycle behind, like the memory word
    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= reset_pc;
            id_pc <= reset_pc;
        end else if (redirect) begin
            pc    <= branch_target;
            id_pc <= pc;
        end else if (!stall) begin
            pc    <= pc + pc_step;
            id_pc <= pc;
        end
    end

endmodule

// ==== rv_fwd_if.sv ====
`timescale 1ns/10ps

interface rv_fwd_if;
    import rv_pkg::*;

    // Instruction in the memory stage
    logic     mem_reg_write;
    reg_idx_t mem_rd;
    word_t    mem_result;

    // Instruction in writeback
    logic     wb_reg_write;
    reg_idx_t wb_rd;
    word_t    wb_data;

    modport source (output mem_reg_write, mem_rd, mem_result,
                    output wb_reg_write, wb_rd, wb_data);

    modport sink (input mem_reg_write, mem_rd, mem_result,
                  input wb_reg_write, wb_rd, wb_data);

endinterface

// ==== rv_pkg.sv ====
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [xlen-1:0]       addr_t;
    typedef logic [31:0]           instr_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // ALU operations, named after the RV32I mnemonics
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    // ALU funct3
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // Branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Instruction bit 30 picks SUB over ADD and SRA over SRL
    localparam int funct7_alt = 30;

    localparam instr_t nop_instr = 32'h0000_0013;
    localparam addr_t  reset_pc  = 32'h0040_0000;
    localparam addr_t  pc_step   = 32'd4;

endpackage
